// ==== hdl/ecc_pkg.sv ====
package ecc_pkg;

    // ******************************************************************
    // Widths of the 23/6 SEC-DED code.
    // ******************************************************************

    localparam int ECC_DATA_W = 23;
    localparam int ECC_PAR_W  = 6;
    localparam int ECC_CW_W   = ECC_DATA_W + ECC_PAR_W;

    // Check bits fed by each data bit, check bit 5 on the left.
    // All codes have odd weight of three or more.
    localparam logic [ECC_PAR_W-1:0] ECC_COL_CODE [0:ECC_DATA_W-1] = '{
        6'b100011,  // Data bit 0.
        6'b100101,
        6'b100110,
        6'b000111,
        6'b101001,
        6'b101010,
        6'b001011,
        6'b101100,
        6'b001101,
        6'b001110,
        6'b101111,  // Data bit 10.
        6'b110001,
        6'b110010,
        6'b010011,
        6'b110100,
        6'b010101,
        6'b010110,
        6'b110111,
        6'b111000,
        6'b011001,
        6'b011010,  // Data bit 20.
        6'b111011,
        6'b011100
    };

    // ******************************************************************
    // Stored codeword, seen flat or as check bits above data.
    // ******************************************************************

    typedef union packed {
        logic [ECC_CW_W-1:0] flat;
        struct packed {
            logic [ECC_PAR_W-1:0]  par;
            logic [ECC_DATA_W-1:0] data;
        } fields;
    } ecc_codeword_u;

    // Each check bit is the XOR of the data bits whose column sets it.
    function automatic logic [ECC_PAR_W-1:0] ecc_parity(
        input logic [ECC_DATA_W-1:0] data
    );
        logic [ECC_PAR_W-1:0] par;
        par = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (data[i]) begin
                par = par ^ ECC_COL_CODE[i];
            end
        end
        return par;
    endfunction

endpackage

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // ******************************************************************
    // Array geometry and error counter size.
    // ******************************************************************

    localparam int MEM_DEPTH  = 32;
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

    localparam int ERR_CNT_W  = 8;  // Counters stop at 255.

endpackage

// ==== hdl/ecc_secded_23.sv ====
`timescale 1ns/1ps

module ecc_secded_23
    import ecc_pkg::*;
(
    input  logic [ECC_DATA_W-1:0] data_in,
    input  logic [ECC_PAR_W-1:0]  parity_in,
    input  logic                  bypass,
    output logic [ECC_DATA_W-1:0] data_out,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    logic [ECC_PAR_W-1:0]  syndrome;
    logic [ECC_DATA_W-1:0] flip_mask;
    logic                  col_hit;
    logic                  chk_hit;
    logic                  sbit_raw;
    logic                  dbit_raw;

    // ******************************************************************
    // Syndrome and decode.
    // ******************************************************************

    assign syndrome = parity_in ^ ecc_parity(data_in);  // Zero for a clean word.

    // Column codes are distinct, so at most one bit of the mask is set.
    always_comb begin
        flip_mask = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (syndrome == ECC_COL_CODE[i]) begin
                flip_mask[i] = 1'b1;
            end
        end
    end

    assign col_hit  = |flip_mask;          // One data bit flipped.
    assign chk_hit  = $onehot(syndrome);   // One check bit flipped.
    assign sbit_raw = col_hit | chk_hit;

    // Two flips give an even, nonzero syndrome that no column matches.
    assign dbit_raw = (syndrome != '0) && !sbit_raw;

    // ******************************************************************
    // Outputs.
    // ******************************************************************

    assign data_out = bypass ? data_in : (data_in ^ flip_mask);
    assign sbit_err = !bypass && sbit_raw;  // Flags are silent in bypass.
    assign dbit_err = !bypass && dbit_raw;

endmodule

// ==== hdl/ecc_mem_array.sv ====
`timescale 1ns/1ps

module ecc_mem_array
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [MEM_ADDR_W-1:0] wr_addr,
    input  logic [ECC_CW_W-1:0]   wr_cw,
    input  logic                  rd_en,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    output logic [ECC_CW_W-1:0]   rd_cw
);

    logic [ECC_CW_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_cw;
        end
    end

    // A read and a write to one address at the same edge return the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_cw <= mem[rd_addr];  // Holds between reads.
        end
    end

endmodule

// ==== hdl/ecc_mem_ctrl.sv ====
`timescale 1ns/1ps

module ecc_mem_ctrl
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [MEM_ADDR_W-1:0] wr_addr,
    input  logic [ECC_DATA_W-1:0] wr_data,
    input  logic [ECC_CW_W-1:0]   inj_mask,
    input  logic                  rd_en,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    input  logic [ECC_DATA_W-1:0] cor_data,
    input  logic                  cor_sbit,
    input  logic                  cor_dbit,
    output logic                  arr_wr_en,
    output logic [MEM_ADDR_W-1:0] arr_wr_addr,
    output logic [ECC_CW_W-1:0]   arr_wr_cw,
    output logic                  rd_valid_nxt,
    output logic                  sbit_err_nxt,
    output logic                  dbit_err_nxt,
    output logic                  rd_valid,
    output logic [ECC_DATA_W-1:0] rd_data,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    ecc_codeword_u         wr_cw;
    ecc_codeword_u         scrub_cw;
    logic                  arr_vld;
    logic [MEM_ADDR_W-1:0] arr_addr;
    logic                  scrub_en;
    logic [MEM_ADDR_W-1:0] scrub_addr;

    // ******************************************************************
    // Array write port: external write first, scrub otherwise.
    // ******************************************************************

    // rd_data holds the corrected word for the cycle after a flagged read.
    always_comb begin
        wr_cw.fields.data    = wr_data;
        wr_cw.fields.par     = ecc_parity(wr_data);
        scrub_cw.fields.data = rd_data;
        scrub_cw.fields.par  = ecc_parity(rd_data);
    end

    assign arr_wr_en   = wr_en | scrub_en;
    assign arr_wr_addr = wr_en ? wr_addr : scrub_addr;
    assign arr_wr_cw   = wr_en ? (wr_cw.flat ^ inj_mask) : scrub_cw.flat;

    // ******************************************************************
    // Read pipeline.
    // ******************************************************************

    assign rd_valid_nxt = arr_vld;              // Array output is live.
    assign sbit_err_nxt = arr_vld & cor_sbit;
    assign dbit_err_nxt = arr_vld & cor_dbit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arr_vld  <= 1'b0;
            rd_valid <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
            scrub_en <= 1'b0;
        end else begin
            arr_vld  <= rd_en;
            rd_valid <= rd_valid_nxt;
            sbit_err <= sbit_err_nxt;
            dbit_err <= dbit_err_nxt;
            scrub_en <= sbit_err_nxt;  // Double errors are never written back.
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            arr_addr <= rd_addr;
        end
        if (arr_vld) begin
            rd_data    <= cor_data;
            scrub_addr <= arr_addr;
        end
    end

endmodule

// ==== hdl/ecc_err_counter.sv ====
`timescale 1ns/1ps

module ecc_err_counter
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cnt_clr,
    input  logic                 rd_valid,
    input  logic                 sbit_err,
    input  logic                 dbit_err,
    output logic [ERR_CNT_W-1:0] sbit_count,
    output logic [ERR_CNT_W-1:0] dbit_count
);

    logic sbit_inc;
    logic dbit_inc;

    // Counting stops at all ones.
    assign sbit_inc = rd_valid && sbit_err && !(&sbit_count);
    assign dbit_inc = rd_valid && dbit_err && !(&dbit_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else if (cnt_clr) begin
            sbit_count <= '0;   // Clear beats a count in the same cycle.
            dbit_count <= '0;
        end else begin
            if (sbit_inc) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_inc) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/ecc_mem_top.sv ====
`timescale 1ns/1ps

module ecc_mem_top
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [MEM_ADDR_W-1:0] wr_addr,
    input  logic [ECC_DATA_W-1:0] wr_data,
    input  logic [ECC_CW_W-1:0]   inj_mask,
    input  logic                  rd_en,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    input  logic                  ecc_bypass,
    output logic                  rd_valid,
    output logic [ECC_DATA_W-1:0] rd_data,
    output logic                  sbit_err,
    output logic                  dbit_err,
    input  logic                  cnt_clr,
    output logic [ERR_CNT_W-1:0]  sbit_count,
    output logic [ERR_CNT_W-1:0]  dbit_count
);

    logic                  arr_wr_en;
    logic [MEM_ADDR_W-1:0] arr_wr_addr;
    logic [ECC_CW_W-1:0]   arr_wr_cw;
    ecc_codeword_u         rd_cw;
    logic [ECC_DATA_W-1:0] cor_data;
    logic                  cor_sbit;
    logic                  cor_dbit;
    logic                  rd_valid_nxt;
    logic                  sbit_err_nxt;
    logic                  dbit_err_nxt;

    // ******************************************************************
    // Controller, storage, corrector and counters.
    // ******************************************************************

    ecc_mem_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .inj_mask     (inj_mask),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .cor_data     (cor_data),
        .cor_sbit     (cor_sbit),
        .cor_dbit     (cor_dbit),
        .arr_wr_en    (arr_wr_en),
        .arr_wr_addr  (arr_wr_addr),
        .arr_wr_cw    (arr_wr_cw),
        .rd_valid_nxt (rd_valid_nxt),
        .sbit_err_nxt (sbit_err_nxt),
        .dbit_err_nxt (dbit_err_nxt),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err)
    );

    ecc_mem_array u_array (
        .clk     (clk),
        .wr_en   (arr_wr_en),
        .wr_addr (arr_wr_addr),
        .wr_cw   (arr_wr_cw),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_cw   (rd_cw)
    );

    ecc_secded_23 u_secded (
        .data_in   (rd_cw.fields.data),  // Low 23 bits of the stored word.
        .parity_in (rd_cw.fields.par),
        .bypass    (ecc_bypass),
        .data_out  (cor_data),
        .sbit_err  (cor_sbit),
        .dbit_err  (cor_dbit)
    );

    // Fed one stage early so a count lines up with rd_valid.
    ecc_err_counter u_err_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_clr    (cnt_clr),
        .rd_valid   (rd_valid_nxt),
        .sbit_err   (sbit_err_nxt),
        .dbit_err   (dbit_err_nxt),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count)
    );

endmodule

// ==== verification/ecc_mem_chk.sv ====
`timescale 1ns/1ps

module ecc_mem_chk
    import mem_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 rd_en,
    input logic                 rd_valid,
    input logic                 sbit_err,
    input logic                 dbit_err,
    input logic                 cnt_clr,
    input logic [ERR_CNT_W-1:0] sbit_count,
    input logic [ERR_CNT_W-1:0] dbit_count
);

    // ******************************************************************
    // Read flags and latency.
    // ******************************************************************

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(sbit_err && dbit_err))
        else $error("sbit_err and dbit_err are high together");

    flags_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (sbit_err || dbit_err) |-> rd_valid)
        else $error("error flag raised without rd_valid");

    valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> ##2 rd_valid)
        else $error("rd_valid missing two edges after rd_en");

    valid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_en, 2))
        else $error("rd_valid without a read two edges earlier");

    // Counts only drop when a clear was sampled on the edge before.
    sbit_count_rises: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(cnt_clr) |-> (sbit_count >= $past(sbit_count)))
        else $error("sbit_count decreased without cnt_clr");

    dbit_count_rises: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(cnt_clr) |-> (dbit_count >= $past(dbit_count)))
        else $error("dbit_count decreased without cnt_clr");

endmodule

bind ecc_mem_top ecc_mem_chk u_chk (.*);

// ==== verification/ecc_mem_tb.sv ====
`timescale 1ns/1ps

module ecc_mem_tb
    import ecc_pkg::*;
    import mem_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [ECC_DATA_W-1:0] wr_data;
    logic [ECC_CW_W-1:0]   inj_mask;
    logic                  rd_en;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic                  ecc_bypass;
    logic                  rd_valid;
    logic [ECC_DATA_W-1:0] rd_data;
    logic                  sbit_err;
    logic                  dbit_err;
    logic                  cnt_clr;
    logic [ERR_CNT_W-1:0]  sbit_count;
    logic [ERR_CNT_W-1:0]  dbit_count;

    logic [ECC_DATA_W-1:0] model_mem [MEM_DEPTH];  // Last data written per address.
    int                    err_cnt;
    int                    check_cnt;
    int                    exp_sbit;
    int                    exp_dbit;
    int unsigned           seed;

    ecc_mem_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ******************************************************************
    // Helpers.
    // ******************************************************************

    task automatic end_on_timeout(input string what);
        err_cnt++;
        $display("timeout while waiting for %s", what);
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got == exp) else begin
            err_cnt++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_word(input logic [MEM_ADDR_W-1:0] addr,
                              input logic [ECC_DATA_W-1:0] data,
                              input ecc_codeword_u mask);
        wr_en    = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        inj_mask = mask.flat;
        @(negedge clk);
        wr_en    = 1'b0;
        inj_mask = '0;
        model_mem[addr] = data;
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!rd_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            end_on_timeout("rd_valid");
        end
    endtask

    task automatic check_result(input logic [ECC_DATA_W-1:0] data, input logic sbit,
                                input logic dbit);
        check_value("rd_data", rd_data, data);
        check_value("sbit_err", sbit_err, sbit);
        check_value("dbit_err", dbit_err, dbit);
    endtask

    task automatic read_word(input logic [MEM_ADDR_W-1:0] addr,
                             input logic [ECC_DATA_W-1:0] data, input logic sbit,
                             input logic dbit);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en = 1'b0;
        @(negedge clk);
        wait_valid();
        check_result(data, sbit, dbit);
        exp_sbit = exp_sbit + sbit;
        exp_dbit = exp_dbit + dbit;
        // The counts already include the result on display.
        check_value("sbit_count", sbit_count, exp_sbit);
        check_value("dbit_count", dbit_count, exp_dbit);
        @(negedge clk);  // Scrub write-back edge, kept free of writes.
    endtask

    // ******************************************************************
    // Directed tests.
    // ******************************************************************

    task automatic clean_round_trip();
        ecc_codeword_u none;
        none.flat = '0;
        for (int a = 0; a < 8; a++) begin
            write_word(a, $urandom(), none);
        end
        for (int a = 0; a < 8; a += 2) begin
            rd_en   = 1'b1;  // Two reads on consecutive cycles.
            rd_addr = a;
            @(negedge clk);
            rd_addr = a + 1;
            @(negedge clk);
            rd_en = 1'b0;
            wait_valid();
            check_result(model_mem[a], 1'b0, 1'b0);
            @(negedge clk);
            wait_valid();
            check_result(model_mem[a + 1], 1'b0, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic single_data_errors();
        ecc_codeword_u         mask;
        logic [ECC_DATA_W-1:0] data;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            data      = $urandom();
            mask.flat = '0;
            mask.fields.data[i] = 1'b1;
            write_word(i, data, mask);
            read_word(i, data, 1'b1, 1'b0);
            read_word(i, data, 1'b0, 1'b0);  // The scrubbed copy is clean.
        end
    endtask

    task automatic single_check_errors();
        ecc_codeword_u         mask;
        logic [ECC_DATA_W-1:0] data;
        for (int j = 0; j < ECC_PAR_W; j++) begin
            data      = $urandom();
            mask.flat = '0;
            mask.fields.par[j] = 1'b1;
            write_word(24 + j, data, mask);
            read_word(24 + j, data, 1'b1, 1'b0);
        end
    endtask

    task automatic double_errors();
        ecc_codeword_u         mask;
        logic [ECC_DATA_W-1:0] data;
        logic [MEM_ADDR_W-1:0] addr;
        int                    b0;
        int                    b1;
        for (int n = 0; n < 8; n++) begin
            data = $urandom();
            addr = $urandom_range(MEM_DEPTH - 1);
            b0   = $urandom_range(ECC_CW_W - 1);
            do begin
                b1 = $urandom_range(ECC_CW_W - 1);
            end while (b1 == b0);
            mask.flat     = '0;
            mask.flat[b0] = 1'b1;
            mask.flat[b1] = 1'b1;
            write_word(addr, data, mask);
            read_word(addr, data ^ mask.fields.data, 1'b0, 1'b1);
        end
    endtask

    task automatic bypass_read();
        ecc_codeword_u         mask;
        logic [ECC_DATA_W-1:0] data;
        data      = $urandom();
        mask.flat = '0;
        mask.fields.data[5] = 1'b1;
        write_word(30, data, mask);
        ecc_bypass = 1'b1;
        read_word(30, data ^ mask.fields.data, 1'b0, 1'b0);
        ecc_bypass = 1'b0;
        read_word(30, data, 1'b1, 1'b0);  // Still faulty, so no scrub ran.
    endtask

    task automatic error_counters();
        ecc_codeword_u         mask;
        logic [ECC_DATA_W-1:0] data;
        int                    issued;
        int                    seen;
        int                    cycles;
        check_value("sbit_count", sbit_count, exp_sbit);
        check_value("dbit_count", dbit_count, exp_dbit);
        cnt_clr = 1'b1;
        @(negedge clk);
        cnt_clr = 1'b0;
        check_value("sbit_count", sbit_count, 0);
        check_value("dbit_count", dbit_count, 0);
        data      = $urandom();
        mask.flat = '0;
        mask.fields.data[7] = 1'b1;
        write_word(5, data, mask);
        issued = 0;
        seen   = 0;
        cycles = 0;
        // Rewriting the faulty word every cycle drops every scrub.
        while (seen < 260) begin
            if (rd_valid) begin
                check_result(data, 1'b1, 1'b0);
                seen++;
            end
            if (issued < 260) begin
                wr_en    = 1'b1;
                wr_addr  = 5;
                wr_data  = data;
                inj_mask = mask.flat;
                rd_en    = 1'b1;
                rd_addr  = 5;
                issued++;
            end else begin
                wr_en    = 1'b0;
                inj_mask = '0;
                rd_en    = 1'b0;
            end
            @(negedge clk);
            cycles++;
            if (cycles > 270) begin
                end_on_timeout("the saturation reads");
            end
        end
        check_value("sbit_count", sbit_count, 255);
        check_value("dbit_count", dbit_count, 0);
    endtask

    initial begin
        seed       = $urandom(4217);  // Seeds the generator for the run.
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        inj_mask   = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        ecc_bypass = 1'b0;
        cnt_clr    = 1'b0;
        err_cnt    = 0;
        check_cnt  = 0;
        exp_sbit   = 0;
        exp_dbit   = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        clean_round_trip();
        single_data_errors();
        single_check_errors();
        double_errors();
        bypass_read();
        error_counters();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/ecc_pkg.sv
hdl/mem_pkg.sv
hdl/ecc_secded_23.sv
hdl/ecc_mem_array.sv
hdl/ecc_mem_ctrl.sv
hdl/ecc_err_counter.sv
hdl/ecc_mem_top.sv
verification/ecc_mem_chk.sv
verification/ecc_mem_tb.sv
